// File: common/video_pkg.sv
// video fetch shared definitions
package video_pkg;

	// graphics modes, vconf[1:0] zero-extended
	typedef enum logic [2:0]
	{
		M_ZX = 3'd0,	// zx screen
		M_HC = 3'd1,	// 16 colour
		M_XC = 3'd2,	// 256 colour
		M_TX = 3'd3,	// text
		M_T2 = 3'd4,	// reserved
		M_T0 = 3'd5,	// zx hi-res
		M_T1 = 3'd6,	// reserved
		M_T3 = 3'd7		// reserved
	} vmode_t;

	// pixel renderer formats
	typedef enum logic [1:0]
	{
		R_ZX = 2'd0,
		R_HC = 2'd1,
		R_XC = 2'd2,
		R_TX = 2'd3
	} render_t;

	// total dram slots per window, video_bw[4:3]
	localparam logic [1:0] BW2 = 2'b00;
	localparam logic [1:0] BW4 = 2'b01;
	localparam logic [1:0] BW8 = 2'b11;

	// slots used by video, video_bw[2:0]
	localparam logic [2:0] BU1 = 3'b001;
	localparam logic [2:0] BU2 = 3'b010;
	localparam logic [2:0] BU4 = 3'b100;

	// raster resolution tables, indexed by vconf[7:6]
	// 256x192, 320x200, 320x240, 360x288
	localparam logic [8:0] HPIX_BEG_T [4] = '{9'd140, 9'd108, 9'd108, 9'd88};
	localparam logic [8:0] HPIX_END_T [4] = '{9'd396, 9'd428, 9'd428, 9'd448};
	localparam logic [8:0] VPIX_BEG_T [4] = '{9'd80, 9'd76, 9'd56, 9'd32};
	localparam logic [8:0] VPIX_END_T [4] = '{9'd272, 9'd276, 9'd296, 9'd320};
	localparam logic [5:0] X_TILES_T [4] = '{6'd33, 6'd41, 6'd41, 6'd46};

	// fetch lead before first visible pixel, per mode
	localparam logic [4:0] GO_OFFS_T [8] = '{
		5'd18,	// zx
		5'd6,	// 16c
		5'd4,	// 256c
		5'd10,	// text
		5'd18,	// reserved
		5'd10,	// zx hi-res
		5'd18,	// reserved
		5'd18	// reserved
	};

	// modes running at the fast pixel rate (text, zx hi-res)
	localparam logic [7:0] HIRES_MASK = 8'b0010_1000;

endpackage

// File: src/video_timing.sv
// raster timing generator
`timescale 1ns/10ps

module video_timing #(
	parameter int H_TOTAL = 448,	// c3 ticks per line
	parameter int V_TOTAL = 320		// lines per frame
) (
	input  logic       clk,
	input  logic       rst,
	output logic       c3,			// every 4th clk
	output logic       f1,			// every 2nd clk
	output logic       line_start,	// level, last pixel of line
	output logic [8:0] hcnt,
	output logic [8:0] vcnt
);

	localparam logic [8:0] H_LAST = 9'(H_TOTAL - 1);
	localparam logic [8:0] V_LAST = 9'(V_TOTAL - 1);

	logic [1:0] phase;	// clk phase within one c3 period

	// phase strobes
	always_ff @(posedge clk)
	begin
		if (rst)
			phase <= 2'd0;
		else
			phase <= phase + 2'd1;
	end

	assign f1 = phase[0];	// phases 1 and 3
	assign c3 = &phase;		// phase 3 only

	// horizontal counter, steps on c3
	always_ff @(posedge clk)
	begin
		if (rst)
			hcnt <= 9'd0;
		else if (c3)
		begin
			if (hcnt == H_LAST)
				hcnt <= 9'd0;	// wrap into next line
			else
				hcnt <= hcnt + 9'd1;
		end
	end

	// vertical counter, steps on horizontal wrap
	always_ff @(posedge clk)
	begin
		if (rst)
			vcnt <= 9'd0;
		else if (c3 && hcnt == H_LAST)
		begin
			if (vcnt == V_LAST)
				vcnt <= 9'd0;	// new frame
			else
				vcnt <= vcnt + 9'd1;
		end
	end

	// held for the whole last tick of the line
	assign line_start = (hcnt == H_LAST);

endmodule

// File: video_mode/video_mode.sv
// video mode decoder
`timescale 1ns/10ps

module video_mode import video_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       c3,
	input  logic       f1,
	input  logic       line_start,
	input  logic [7:0] vconf,
	input  logic [7:0] vpage,
	input  logic [3:0] palsel,
	input  logic [8:0] gx_offs,
	input  logic       zvpage_wr,	// cpu write to page reg
	input  logic [7:0] cnt_col,
	input  logic [8:0] cnt_row,
	input  logic       cptr,
	output vmode_t     vmode,
	output render_t    render_mode,
	output logic [7:0] vpage_d,
	output logic [3:0] palsel_d,
	output logic [4:0] go_offs,
	output logic [8:0] hpix_beg,
	output logic [8:0] hpix_end,
	output logic [8:0] vpix_beg,
	output logic [8:0] vpix_end,
	output logic [5:0] x_tiles,
	output logic [3:0] fetch_sel,	// byte lane enables
	output logic [1:0] fetch_bsl,	// byte swap select
	output logic [9:0] x_offs_mode,
	output logic       tv_hires,
	output logic       vga_hires,
	output logic       pix_stb,
	output logic       nogfx
);

	logic [7:0] vconf_d;	// config in effect for this line
	logic [8:0] gx_offs_d;
	logic [1:0] rres;		// resolution index
	logic       latch;

	assign latch = line_start & c3;	// edge into hcnt 0

	// configuration taken once per line
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			vconf_d   <= 8'd0;
			gx_offs_d <= 9'd0;
			palsel_d  <= 4'd0;
			vga_hires <= 1'b0;
		end
		else if (latch)
		begin
			vconf_d   <= vconf;
			gx_offs_d <= gx_offs;
			palsel_d  <= palsel;
			vga_hires <= tv_hires;	// scan doubler lags a line
		end
	end

	// page may also be rewritten mid-line by the cpu
	always_ff @(posedge clk)
	begin
		if (rst)
			vpage_d <= 8'd0;
		else if (latch || zvpage_wr)
			vpage_d <= vpage;
	end

	assign vmode = vmode_t'({1'b0, vconf_d[1:0]});
	assign rres  = vconf_d[7:6];
	assign nogfx = vconf_d[5];

	// mode tables
	assign go_offs  = GO_OFFS_T[vmode];
	assign tv_hires = HIRES_MASK[vmode];
	assign pix_stb  = tv_hires ? f1 : c3;	// 2x pixel rate in hi-res

	always_comb
	begin
		case (vmode)
			M_HC:    render_mode = R_HC;
			M_XC:    render_mode = R_XC;
			M_TX:    render_mode = R_TX;
			default: render_mode = R_ZX;	// zx, hi-res and reserved
		endcase
	end

	// resolution tables
	assign hpix_beg = HPIX_BEG_T[rres];
	assign hpix_end = HPIX_END_T[rres];
	assign vpix_beg = VPIX_BEG_T[rres];
	assign vpix_end = VPIX_END_T[rres];
	assign x_tiles  = X_TILES_T[rres];

	// fetch selectors, column already advanced when data lands
	always_comb
	begin
		fetch_sel = {~cptr, ~cptr, cptr, cptr};	// zx pixel/attr alternate
		fetch_bsl = 2'b10;
		case (vmode)
			M_HC, M_XC:
				fetch_sel = {~cptr, ~cptr, 2'b11};
			M_TX:
			begin
				case (cnt_col[1:0])
					2'd1:    fetch_sel = 4'b0011;	// char codes
					2'd2:    fetch_sel = 4'b1100;	// attributes
					2'd3:    fetch_sel = 4'b0001;	// glyph 0
					default: fetch_sel = 4'b0010;	// glyph 1
				endcase
				if (cnt_col[1:0] == 2'd3 || cnt_col[1:0] == 2'd0)
					fetch_bsl = {2{cnt_row[0]}};	// glyph byte by row parity
			end
			default: ;
		endcase
	end

	// x scroll, 256c keeps pixel pairs
	assign x_offs_mode = (vmode == M_XC) ?
		{gx_offs_d[8:1], 1'b0, gx_offs_d[0]} :
		{1'b0, gx_offs_d[8:1], gx_offs_d[0]};

endmodule

// File: video_mode/video_addr.sv
// video dram address generator
`timescale 1ns/10ps

module video_addr import video_pkg::*; (
	input  vmode_t      vmode,
	input  logic [7:0]  vpage_d,
	input  logic [7:0]  cnt_col,
	input  logic [8:0]  cnt_row,
	input  logic [8:0]  vcnt,		// raw line, used as tile row
	input  logic [1:0]  tm_en,		// tile plane enables
	input  logic        tm_pf,		// tilemap prefetch phase
	input  logic [15:0] txt_char,	// two char codes from last fetch
	output logic [20:0] video_addr,
	output logic [4:0]  video_bw,
	output logic [8:0]  tmb_waddr
);

	logic [20:0] addr_zx;
	logic [11:0] addr_zx_gfx;
	logic [11:0] addr_zx_atr;
	logic [20:0] addr_16c;
	logic [20:0] addr_256c;
	logic [13:0] addr_tx;
	logic [20:0] addr_text;
	logic [20:0] tm_addr;
	logic [2:0]  tp_col;
	logic        tpn;			// tile plane number
	logic [20:0] mode_addr;
	logic [4:0]  mode_bw;

	// zx screen, pixel on even col, attr on odd
	assign addr_zx_gfx = {cnt_row[7:6], cnt_row[2:0], cnt_row[5:3], cnt_col[4:1]};
	assign addr_zx_atr = {3'b110, cnt_row[7:3], cnt_col[4:1]};
	assign addr_zx     = {vpage_d, 1'b0, cnt_col[0] ? addr_zx_atr : addr_zx_gfx};

	// linear bitmaps
	assign addr_16c  = {vpage_d[7:3], cnt_row, cnt_col[6:0]};
	assign addr_256c = {vpage_d[7:4], cnt_row, cnt_col};

	// text, four fetch kinds cycled by col
	always_comb
	begin
		case (cnt_col[1:0])
			2'd0:    addr_tx = {vpage_d[0], cnt_row[8:3], 1'b0, cnt_col[7:2]};	// char
			2'd1:    addr_tx = {vpage_d[0], cnt_row[8:3], 1'b1, cnt_col[7:2]};	// attr
			2'd2:    addr_tx = {~vpage_d[0], 3'b000, txt_char[7:0], cnt_row[2:1]};
			default: addr_tx = {~vpage_d[0], 3'b000, txt_char[15:8], cnt_row[2:1]};
		endcase
	end
	assign addr_text = {vpage_d[7:1], addr_tx};

	// tilemap, two planes interleave on col bit 0
	assign tp_col    = (&tm_en) ? cnt_col[3:1] : cnt_col[2:0];
	assign tpn       = (&tm_en) ? cnt_col[0] : tm_en[1];
	assign tm_addr   = {vpage_d, vcnt[8:3], tpn, vcnt[2:0], tp_col};
	assign tmb_waddr = {vcnt[4:0], tp_col, tpn};

	// per-mode address and slot usage
	always_comb
	begin
		mode_addr = addr_zx;
		mode_bw   = {BW8, BU1};
		case (vmode)
			M_HC:
			begin
				mode_addr = addr_16c;
				mode_bw   = {BW4, BU1};
			end
			M_XC:
			begin
				mode_addr = addr_256c;
				mode_bw   = {BW2, BU1};
			end
			M_TX:
			begin
				mode_addr = addr_text;
				mode_bw   = {BW8, BU4};	// 4 of 8
			end
			M_T0: mode_bw = {BW8, BU2};	// hi-res zx, 2 of 8
			default: ;
		endcase
	end

	assign video_addr = tm_pf ? tm_addr : mode_addr;
	assign video_bw   = tm_pf ? {BW4, (&tm_en) ? BU2 : BU1} : mode_bw;

endmodule

// File: src/fetch_sched.sv
// video fetch scheduler
`timescale 1ns/10ps

module fetch_sched import video_pkg::*; #(
	parameter int H_TOTAL = 448,
	parameter int V_TOTAL = 320
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       c3,
	input  logic [8:0] hcnt,
	input  logic [8:0] vcnt,
	input  logic       line_start,
	input  render_t    render_mode,
	input  logic [4:0] go_offs,
	input  logic [8:0] hpix_beg,
	input  logic [8:0] hpix_end,
	input  logic [8:0] vpix_beg,
	input  logic [8:0] vpix_end,
	output logic       fetch_stb,
	output logic [7:0] cnt_col,
	output logic [8:0] cnt_row,
	output logic       cptr
);

	localparam logic [8:0] H_LAST = 9'(H_TOTAL - 1);
	localparam logic [8:0] V_LIM  = 9'(V_TOTAL);

	logic [8:0] x_beg, x_end_raw, x_end;
	logic [8:0] v_end;
	logic       v_vis;		// line inside vertical window
	logic       pix_start;
	logic       win;		// fetch window open
	logic [3:0] fetch_cnt;
	logic       ftch;		// pacing tick for render mode
	logic       line_go;	// first clk of hcnt 0

	// window bounds, led by go_offs, kept inside the raster
	assign x_beg     = hpix_beg - 9'(go_offs);
	assign x_end_raw = hpix_end - 9'(go_offs);
	assign x_end     = (x_end_raw > H_LAST) ? H_LAST : x_end_raw;
	assign v_end     = (vpix_end > V_LIM) ? V_LIM : vpix_end;
	assign v_vis     = (vcnt >= vpix_beg) && (vcnt < v_end);
	assign pix_start = c3 && v_vis && (hcnt == x_beg);

	always_comb
	begin
		case (render_mode)
			R_HC:    ftch = &fetch_cnt[1:0];	// every 4 ticks
			R_XC:    ftch = fetch_cnt[0];		// every 2 ticks
			default: ftch = &fetch_cnt;			// zx and text, every 16
		endcase
	end

	assign fetch_stb = pix_start || (c3 && win && ftch);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			win       <= 1'b0;
			fetch_cnt <= 4'd0;
			line_go   <= 1'b0;
		end
		else
		begin
			line_go <= line_start & c3;
			if (pix_start)
			begin
				win       <= 1'b1;
				fetch_cnt <= 4'd0;
			end
			else if (c3 && win)
			begin
				fetch_cnt <= fetch_cnt + 4'd1;
				if (hcnt == x_end)
					win <= 1'b0;	// last tick of the window
			end
		end
	end

	// column and buffer pointer, advanced after each strobe
	always_ff @(posedge clk)
	begin
		if (rst || (line_start && c3))
		begin
			cnt_col <= 8'd0;
			cptr    <= 1'b0;
		end
		else if (fetch_stb)
		begin
			cnt_col <= cnt_col + 8'd1;
			cptr    <= ~cptr;
		end
	end

	// row relative to window top, taken once new vcnt is valid
	always_ff @(posedge clk)
	begin
		if (rst)
			cnt_row <= 9'd0;
		else if (line_go)
			cnt_row <= vcnt - vpix_beg;
	end

endmodule

// File: src/video_fetch_top.sv
// video fetch subsystem top
`timescale 1ns/10ps

module video_fetch_top import video_pkg::*; #(
	parameter int H_TOTAL = 448,
	parameter int V_TOTAL = 320
) (
	input  logic        clk,
	input  logic        rst,
	input  logic [7:0]  vconf,
	input  logic [7:0]  vpage,
	input  logic [3:0]  palsel,
	input  logic [8:0]  gx_offs,
	input  logic        zvpage_wr,
	input  logic [1:0]  tm_en,
	input  logic        tm_pf,
	input  logic [15:0] txt_char,
	output logic [20:0] video_addr,
	output logic [8:0]  tmb_waddr,
	output logic [4:0]  video_bw,
	output logic [3:0]  fetch_sel,
	output logic [1:0]  fetch_bsl,
	output logic [9:0]  x_offs_mode,
	output logic        pix_stb,
	output logic        tv_hires,
	output logic        vga_hires,
	output logic        nogfx,
	output logic [7:0]  vpage_d,
	output logic [3:0]  palsel_d,
	output logic        fetch_stb
);

	logic       c3, f1, line_start;
	logic [8:0] hcnt, vcnt;
	vmode_t     vmode;
	render_t    render_mode;
	logic [4:0] go_offs;
	logic [8:0] hpix_beg, hpix_end, vpix_beg, vpix_end;
	logic [7:0] cnt_col;
	logic [8:0] cnt_row;
	logic       cptr;

	video_timing #(.H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL)) video_timing_inst (
		.clk(clk), .rst(rst), .c3(c3), .f1(f1), .line_start(line_start),
		.hcnt(hcnt), .vcnt(vcnt)
	);

	video_mode video_mode_inst (
		.clk(clk), .rst(rst), .c3(c3), .f1(f1), .line_start(line_start),
		.vconf(vconf), .vpage(vpage), .palsel(palsel), .gx_offs(gx_offs),
		.zvpage_wr(zvpage_wr), .cnt_col(cnt_col), .cnt_row(cnt_row), .cptr(cptr),
		.vmode(vmode), .render_mode(render_mode), .vpage_d(vpage_d),
		.palsel_d(palsel_d), .go_offs(go_offs), .hpix_beg(hpix_beg),
		.hpix_end(hpix_end), .vpix_beg(vpix_beg), .vpix_end(vpix_end),
		.x_tiles(), .fetch_sel(fetch_sel), .fetch_bsl(fetch_bsl),
		.x_offs_mode(x_offs_mode), .tv_hires(tv_hires), .vga_hires(vga_hires),
		.pix_stb(pix_stb), .nogfx(nogfx)
	);

	video_addr video_addr_inst (
		.vmode(vmode), .vpage_d(vpage_d), .cnt_col(cnt_col), .cnt_row(cnt_row),
		.vcnt(vcnt), .tm_en(tm_en), .tm_pf(tm_pf), .txt_char(txt_char),
		.video_addr(video_addr), .video_bw(video_bw), .tmb_waddr(tmb_waddr)
	);

	fetch_sched #(.H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL)) fetch_sched_inst (
		.clk(clk), .rst(rst), .c3(c3), .hcnt(hcnt), .vcnt(vcnt),
		.line_start(line_start), .render_mode(render_mode), .go_offs(go_offs),
		.hpix_beg(hpix_beg), .hpix_end(hpix_end), .vpix_beg(vpix_beg),
		.vpix_end(vpix_end), .fetch_stb(fetch_stb), .cnt_col(cnt_col),
		.cnt_row(cnt_row), .cptr(cptr)
	);

endmodule

// File: bench/video_clk_gen.sv
// testbench clock and reset
`timescale 1ns/10ps

module video_clk_gen (
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;	// 8 ns period
	end

	initial
	begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		#1 rst = 1'b0;	// released with the other inputs
	end

endmodule

// File: bench/video_fetch_checker.sv
// fetch strobe and latch assertions
`timescale 1ns/10ps

module video_fetch_checker import video_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       c3,
	input  logic       line_start,
	input  logic       fetch_stb,
	input  render_t    render_mode,
	input  logic       tv_hires,
	input  logic       nogfx,
	input  logic [3:0] palsel_d,
	input  logic [9:0] x_offs_mode
);

	int err_cnt;	// failed assertions so far

	initial err_cnt = 0;

	// c3 once every 4 clk
	c3_period: assert property (@(posedge clk) disable iff (rst) c3 |=> !c3 [*3] ##1 c3)
	else
	begin
		$error("c3 did not repeat every 4 clk");
		err_cnt++;
	end

	// strobes only on the slow phase
	stb_on_c3: assert property (@(posedge clk) disable iff (rst) fetch_stb |-> c3)
	else
	begin
		$error("fetch_stb high without c3");
		err_cnt++;
	end

	// mode decode moves only right after the line latch
	cfg_stable: assert property (@(posedge clk) disable iff (rst)
		!$past(line_start && c3) |-> $stable({render_mode, tv_hires, nogfx, palsel_d, x_offs_mode}))
	else
	begin
		$error("latched configuration changed mid-line");
		err_cnt++;
	end

endmodule

// File: bench/video_fetch_tb.sv
// video fetch testbench
`timescale 1ns/10ps

module video_fetch_tb import video_pkg::*; ();

	localparam int H_TOTAL     = 448;
	localparam int V_TOTAL     = 60;	// short frame, windows come early
	localparam int N_LINES     = 64;
	localparam int N_CYCLES    = N_LINES * H_TOTAL * 4;
	localparam int WATCHDOG_NS = N_CYCLES * 8 + 4000;	// plus reset and slack
	localparam logic [31:0] SEED = 32'h4d6eed4d;
	localparam int HBEG [4] = '{140, 108, 108, 88};
	localparam int HEND [4] = '{396, 428, 428, 448};
	localparam int VBEG [4] = '{80, 76, 56, 32};
	localparam int VEND [4] = '{272, 276, 296, 320};

	logic        clk;
	logic        rst;
	logic [7:0]  vconf;
	logic [7:0]  vpage;
	logic [3:0]  palsel;
	logic [8:0]  gx_offs;
	logic        zvpage_wr;
	logic [1:0]  tm_en;
	logic        tm_pf;
	logic [15:0] txt_char;
	logic [20:0] video_addr;
	logic [8:0]  tmb_waddr;
	logic [4:0]  video_bw;
	logic [3:0]  fetch_sel;
	logic [1:0]  fetch_bsl;
	logic [9:0]  x_offs_mode;
	logic        pix_stb;
	logic        tv_hires;
	logic        vga_hires;
	logic        nogfx;
	logic [7:0]  vpage_d;
	logic [3:0]  palsel_d;
	logic        fetch_stb;

	// reference model state
	logic [1:0]  m_phase;
	int          m_hcnt;
	int          m_vcnt;
	logic [7:0]  m_vconf;		// config of the current line
	logic [7:0]  m_vpage;
	logic [3:0]  m_pal;
	logic [8:0]  m_gx;			// x scroll of the current line
	logic        m_vga_hires;
	logic        m_win;			// fetch window open
	int          m_fcnt;
	logic [7:0]  m_col;
	logic        m_cptr;
	logic [8:0]  m_row;
	logic        m_line_go;		// first clk of a new line
	int          stb_cnt;		// dut strobes in this line
	logic [31:0] rng;

	video_clk_gen clk_gen_inst (.clk(clk), .rst(rst));

	video_fetch_top #(.H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL)) video_fetch_top_inst (
		.clk(clk), .rst(rst), .vconf(vconf), .vpage(vpage), .palsel(palsel),
		.gx_offs(gx_offs), .zvpage_wr(zvpage_wr), .tm_en(tm_en), .tm_pf(tm_pf),
		.txt_char(txt_char), .video_addr(video_addr), .tmb_waddr(tmb_waddr),
		.video_bw(video_bw), .fetch_sel(fetch_sel), .fetch_bsl(fetch_bsl),
		.x_offs_mode(x_offs_mode), .pix_stb(pix_stb), .tv_hires(tv_hires),
		.vga_hires(vga_hires), .nogfx(nogfx), .vpage_d(vpage_d), .palsel_d(palsel_d),
		.fetch_stb(fetch_stb)
	);

	bind video_fetch_top video_fetch_checker checker_inst (
		.clk(clk), .rst(rst), .c3(c3), .line_start(line_start), .fetch_stb(fetch_stb),
		.render_mode(render_mode), .tv_hires(tv_hires), .nogfx(nogfx),
		.palsel_d(palsel_d), .x_offs_mode(x_offs_mode)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int cur_mode();
		return int'(m_vconf[1:0]);
	endfunction

	function automatic int cur_res();
		return int'(m_vconf[7:6]);
	endfunction

	function automatic int lead();	// fetch lead ahead of first pixel
		case (cur_mode())
			1:       return 6;
			2:       return 4;
			3:       return 10;
			default: return 18;
		endcase
	endfunction

	function automatic int stb_period();	// c3 ticks between strobes
		case (cur_mode())
			1:       return 4;
			2:       return 2;
			default: return 16;
		endcase
	endfunction

	function automatic logic exp_c3();
		return m_phase == 2'd3;
	endfunction

	function automatic logic in_rows();
		int vend;
		vend = (VEND[cur_res()] < V_TOTAL) ? VEND[cur_res()] : V_TOTAL;
		return (m_vcnt >= VBEG[cur_res()]) && (m_vcnt < vend);
	endfunction

	function automatic int win_beg();
		return HBEG[cur_res()] - lead();
	endfunction

	function automatic int win_end();
		return HEND[cur_res()] - lead();
	endfunction

	function automatic logic exp_pix_start();
		return exp_c3() && in_rows() && (m_hcnt == win_beg());
	endfunction

	function automatic logic exp_fetch_stb();
		int p;
		p = stb_period();
		return exp_pix_start() || (exp_c3() && m_win && (m_fcnt % p) == p - 1);
	endfunction

	function automatic render_t exp_render();
		case (cur_mode())
			1:       return R_HC;
			2:       return R_XC;
			3:       return R_TX;
			default: return R_ZX;
		endcase
	endfunction

	function automatic logic [4:0] exp_bw();
		if (tm_pf)
			return {BW4, (tm_en == 2'b11) ? BU2 : BU1};	// one slot per plane
		case (cur_mode())
			1:       return {BW4, BU1};
			2:       return {BW2, BU1};
			3:       return {BW8, BU4};
			default: return {BW8, BU1};
		endcase
	endfunction

	function automatic int tile_col();
		return (tm_en == 2'b11) ? int'(m_col[3:1]) : int'(m_col[2:0]);
	endfunction

	function automatic int tile_plane();
		return (tm_en == 2'b11) ? int'(m_col[0]) : int'(tm_en[1]);
	endfunction

	function automatic logic [8:0] exp_waddr();
		return 9'(((m_vcnt & 31) << 4) | (tile_col() << 1) | tile_plane());
	endfunction

	function automatic logic [20:0] exp_addr();
		int row;
		int col;
		int pg;
		int ch;
		int off;
		row = m_row;
		col = m_col;
		pg  = m_vpage;
		if (tm_pf)
			return 21'((pg << 13) | ((m_vcnt >> 3) << 7) | (tile_plane() << 6) |
				((m_vcnt & 7) << 3) | tile_col());
		case (cur_mode())
			1: return 21'(((pg >> 3) << 16) | (row << 7) | (col & 127));
			2: return 21'(((pg >> 4) << 17) | (row << 8) | col);
			3:
			begin
				ch = ((col & 3) == 2) ? int'(txt_char[7:0]) : int'(txt_char[15:8]);
				if ((col & 3) < 2)	// char code then attribute
					off = ((pg & 1) << 13) | ((row >> 3) << 7) | ((col & 1) << 6) | (col >> 2);
				else				// glyph rows of the fetched chars
					off = (((pg & 1) ^ 1) << 13) | (ch << 2) | ((row >> 1) & 3);
				return 21'(((pg >> 1) << 14) | off);
			end
			default:
			begin
				if (col & 1)	// attribute area
					off = 'hC00 | (((row >> 3) & 31) << 4) | ((col >> 1) & 15);
				else			// thirds, pixel line, char row
					off = (((row >> 6) & 3) << 10) | ((row & 7) << 7) |
						(((row >> 3) & 7) << 4) | ((col >> 1) & 15);
				return 21'((pg << 13) | off);
			end
		endcase
	endfunction

	function automatic logic [3:0] exp_sel();
		case (cur_mode())
			1, 2: return {~m_cptr, ~m_cptr, 2'b11};
			3:
			begin
				case (m_col[1:0])
					2'd1:    return 4'b0011;
					2'd2:    return 4'b1100;
					2'd3:    return 4'b0001;
					default: return 4'b0010;
				endcase
			end
			default: return {~m_cptr, ~m_cptr, m_cptr, m_cptr};
		endcase
	endfunction

	function automatic logic [1:0] exp_bsl();
		if (cur_mode() == 3 && (m_col[1:0] == 2'd3 || m_col[1:0] == 2'd0))
			return {2{m_row[0]}};
		return 2'b10;
	endfunction

	function automatic logic [9:0] exp_offs();
		int g;
		g = m_gx;
		if (cur_mode() == 2)	// 256c scrolls the coarse part in pixel pairs
			return 10'(((g >> 1) << 2) | (g & 1));
		return 10'(g);
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_addr(input string name, input logic [20:0] got, input logic [20:0] exp);
		if (got !== exp)
			stop_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time));
	endtask

	task automatic check_bw(input string name, input logic [4:0] got, input logic [4:0] exp);
		if (got !== exp)
			stop_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time));
	endtask

	task automatic check_render(input string name, input render_t got, input render_t exp);
		if (got !== exp)
			stop_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time));
	endtask

	task automatic check_sel(input string name, input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp)
			stop_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time));
	endtask

	task automatic check_reg(input string name, input logic [8:0] got, input logic [8:0] exp);
		if (got !== exp)
			stop_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time));
	endtask

	task automatic check_offs(input string name, input logic [9:0] got, input logic [9:0] exp);
		if (got !== exp)
			stop_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			stop_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time));
	endtask

	task automatic model_reset();
		m_phase     = 2'd0;
		m_hcnt      = 0;
		m_vcnt      = 0;
		m_vconf     = 8'd0;
		m_vpage     = 8'd0;
		m_pal       = 4'd0;
		m_gx        = 9'd0;
		m_vga_hires = 1'b0;
		m_win       = 1'b0;
		m_fcnt      = 0;
		m_col       = 8'd0;
		m_cptr      = 1'b0;
		m_row       = 9'd0;
		m_line_go   = 1'b0;
	endtask

	// one clk edge of the reference, inputs as seen before the edge
	task automatic model_step();
		logic c3m;
		logic latch;
		logic stb;
		logic pix;
		c3m   = exp_c3();
		latch = c3m && (m_hcnt == H_TOTAL - 1);
		stb   = exp_fetch_stb();
		pix   = exp_pix_start();
		if (rst)
			model_reset();
		else
		begin
			if (m_line_go)
				m_row = 9'(m_vcnt - VBEG[cur_res()]);	// new line, new config
			m_line_go = latch;
			if (pix)
			begin
				m_win  = 1'b1;
				m_fcnt = 0;
			end
			else if (c3m && m_win)
			begin
				if (m_hcnt == win_end())
					m_win = 1'b0;
				m_fcnt = (m_fcnt + 1) % 16;
			end
			if (latch)
			begin
				m_col  = 8'd0;
				m_cptr = 1'b0;
			end
			else if (stb)
			begin
				m_col  = m_col + 8'd1;
				m_cptr = ~m_cptr;
			end
			if (latch || zvpage_wr)
				m_vpage = vpage;
			if (latch)
			begin
				m_vga_hires = (m_vconf[1:0] == 2'd3);	// old line's rate
				m_vconf     = vconf;
				m_pal       = palsel;
				m_gx        = gx_offs;
			end
			if (c3m)
				m_hcnt = (m_hcnt == H_TOTAL - 1) ? 0 : m_hcnt + 1;
			if (latch)
				m_vcnt = (m_vcnt == V_TOTAL - 1) ? 0 : m_vcnt + 1;
			m_phase = m_phase + 2'd1;
		end
	endtask

	task automatic check_outputs();
		logic stb;
		int   exp_cnt;
		stb = exp_fetch_stb();
		if (video_fetch_top_inst.checker_inst.err_cnt != 0)
			stop_run("a bound checker assertion failed");
		check_flag("c3", video_fetch_top_inst.c3, exp_c3());
		check_flag("fetch_stb", fetch_stb, stb);
		check_flag("pix_stb", pix_stb, (m_vconf[1:0] == 2'd3) ? m_phase[0] : exp_c3());
		check_flag("tv_hires", tv_hires, m_vconf[1:0] == 2'd3);	// text is the fast rate
		check_flag("vga_hires", vga_hires, m_vga_hires);
		check_flag("nogfx", nogfx, m_vconf[5]);
		check_offs("x_offs_mode", x_offs_mode, exp_offs());
		check_reg("vpage_d", 9'(vpage_d), 9'(m_vpage));
		check_reg("palsel_d", 9'(palsel_d), 9'(m_pal));
		check_render("render_mode", video_fetch_top_inst.render_mode, exp_render());
		check_bw("video_bw", video_bw, exp_bw());
		if (stb || tm_pf)
			check_addr("video_addr", video_addr, exp_addr());
		if (tm_pf)
			check_reg("tmb_waddr", tmb_waddr, exp_waddr());
		if (stb)
		begin
			check_sel("fetch_sel", fetch_sel, exp_sel());
			check_sel("fetch_bsl", 4'(fetch_bsl), 4'(exp_bsl()));
		end
		if (fetch_stb)
			stb_cnt++;
		if (exp_c3() && m_hcnt == H_TOTAL - 1)	// last tick, tally the line
		begin
			exp_cnt = in_rows() ? (win_end() - win_beg()) / stb_period() + 1 : 0;
			check_count("fetch_stb per line", stb_cnt, exp_cnt);
			stb_cnt = 0;
		end
	endtask

	task automatic drive_inputs();
		zvpage_wr = 1'b0;
		rng       = xorshift32(rng);
		txt_char  = rng[31:16];
		if (rng[9:0] == 10'd0)	// about twice a line
		begin
			rng     = xorshift32(rng);
			vconf   = {(rng[1:0] == 2'd0) ? rng[3:2] : 2'b11, rng[9:4]};	// mostly tall raster
			gx_offs = rng[18:10];
			palsel  = rng[22:19];
		end
		else if (rng[10:3] == 8'ha5)
		begin
			rng       = xorshift32(rng);
			vpage     = rng[7:0];
			zvpage_wr = 1'b1;
		end
		if (m_hcnt == 0 && m_phase == 2'd0)	// tilemap phase held per line
		begin
			rng   = xorshift32(rng);
			tm_pf = (rng[1:0] == 2'd0);
			tm_en = rng[3:2];
		end
	endtask

	initial
	begin
		int cyc;
		vconf     = 8'd0;
		vpage     = 8'd0;
		palsel    = 4'd0;
		gx_offs   = 9'd0;
		zvpage_wr = 1'b0;
		tm_en     = 2'd0;
		tm_pf     = 1'b0;
		txt_char  = 16'd0;
		rng       = SEED;
		stb_cnt   = 0;
		model_reset();
		for (cyc = 0; cyc < N_CYCLES; cyc++)
		begin
			@(posedge clk);
			model_step();
			#1;
			drive_inputs();
			@(negedge clk);	// outputs settled
			check_outputs();
		end
		$display("Verification passed");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout, run did not finish within %0d ns", WATCHDOG_NS);
		$display("Verification failed");
		$fatal(1);
	end

endmodule

// File: video_fetch_top.f
common/video_pkg.sv
src/video_timing.sv
video_mode/video_mode.sv
video_mode/video_addr.sv
src/fetch_sched.sv
src/video_fetch_top.sv
bench/video_clk_gen.sv
bench/video_fetch_checker.sv
bench/video_fetch_tb.sv
